/* Makefile */
# Verilator build, run and lint for the control bus core
VERILATOR ?= verilator
TOP       ?= tb_u2_ctrl
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not complete"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
+incdir+.
u2_pkg.sv
wb_decoder.sv
settings_regs.sv
status_readback.sv
pic.sv
u2_ctrl_top.sv
tb_u2_ctrl.sv

/* pic.sv */
// Interrupt controller
// Edge-latched pending bits, enable mask and one combined output
`timescale 1ns/1ps
`include "u2_defs.svh"

module pic (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  u2_pkg::slv_req_t  req_i,
   output logic [`U2_DW-1:0] rd_dat_o,
   input  u2_pkg::irq_vec_t  irq_i,
   output logic              int_o
);

   u2_pkg::irq_vec_t irq_q;
   u2_pkg::irq_vec_t edge_q;
   u2_pkg::irq_vec_t pend_q;
   u2_pkg::irq_vec_t mask_q;
   u2_pkg::irq_vec_t clr;
   logic             wr_stb;

   assign wr_stb = req_i.stb && req_i.we;

   ////////////////////////////////////////////////////////////
   // Edge detect
   // Previous sample and registered rising edges
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         irq_q  <= '0;
         edge_q <= '0;
      end else begin
         irq_q  <= irq_i;
         edge_q <= irq_i & ~irq_q;
      end
   end

   // Write one to clear
   assign clr = (wr_stb && (req_i.idx == `U2_PIC_PENDING)) ? req_i.dat[`U2_IRQ_W-1:0] : '0;

   ////////////////////////////////////////////////////////////
   // Pending and mask registers
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         pend_q <= '0;
         mask_q <= '0;
      end else begin
         // New edge wins over a clear in the same cycle
         pend_q <= (pend_q & ~clr) | edge_q;
         if (wr_stb && (req_i.idx == `U2_PIC_ENABLE)) begin
            mask_q <= req_i.dat[`U2_IRQ_W-1:0];
         end
      end
   end

   assign int_o = |(pend_q & mask_q);

   // Register read-back
   always_comb begin
      case (req_i.idx)
         `U2_PIC_ENABLE:  rd_dat_o = {{(`U2_DW-`U2_IRQ_W){1'b0}}, mask_q};
         `U2_PIC_PENDING: rd_dat_o = {{(`U2_DW-`U2_IRQ_W){1'b0}}, pend_q};
         default:         rd_dat_o = '0;
      endcase
   end

   // No interrupt out while every line is masked
   a_mask_zero_quiet : assert property (@(posedge wb_clk) disable iff (wb_rst)
      (mask_q == '0) |-> !int_o)
      else $error("pic interrupt raised with a zero enable mask");

endmodule

/* settings_regs.sv */
// Settings bus registers for the board control lines
// Clock gen, SERDES, ADC, PHY reset and the LED source mux
`timescale 1ns/1ps
`include "u2_defs.svh"

module settings_regs (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  u2_pkg::slv_req_t     req_i,
   output logic [`U2_DW-1:0]    rd_dat_o,
   input  u2_pkg::hw_status_t   hw_i,
   output u2_pkg::ctrl_out_t    ctrl_o,
   output logic [`U2_LED_W-1:0] leds_o
);

   logic                wr_stb;
   logic [4:0]          clk_q;
   logic [3:0]          ser_q;
   logic [3:0]          adc_q;
   logic                phy_q;
   logic [`U2_LED_W-1:0] led_sw_q;
   logic [`U2_LED_W-1:0] led_src_q;
   logic [`U2_LED_W-1:0] led_hw;

   // Only writes reach the setting registers
   assign wr_stb = req_i.stb && req_i.we;

   ////////////////////////////////////////////////////////////
   // Setting registers
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         clk_q     <= '0;
         ser_q     <= '0;
         adc_q     <= '0;
         phy_q     <= 1'b0;
         led_sw_q  <= '0;
         led_src_q <= `U2_LED_SRC_RESET;
      end else if (wr_stb) begin
         case (req_i.idx)
            `U2_SR_CLK:     clk_q     <= req_i.dat[4:0];
            `U2_SR_SERDES:  ser_q     <= req_i.dat[3:0];
            `U2_SR_ADC:     adc_q     <= req_i.dat[3:0];
            `U2_SR_LED_SW:  led_sw_q  <= req_i.dat[`U2_LED_W-1:0];
            `U2_SR_PHY:     phy_q     <= req_i.dat[0];
            `U2_SR_LED_SRC: led_src_q <= req_i.dat[`U2_LED_W-1:0];
            // Unused addresses fall through
            default: ;
         endcase
      end
   end

   // Write-only bus
   assign rd_dat_o = '0;

   ////////////////////////////////////////////////////////////
   // Board control lines
   assign ctrl_o.clock_ready = clk_q[4];
   assign ctrl_o.clk_en      = clk_q[3:2];
   assign ctrl_o.clk_sel     = clk_q[1:0];
   assign ctrl_o.ser_enable  = ser_q[3];
   assign ctrl_o.ser_prbsen  = ser_q[2];
   assign ctrl_o.ser_loopen  = ser_q[1];
   assign ctrl_o.ser_rx_en   = ser_q[0];
   assign ctrl_o.adc_oe_a    = adc_q[3];
   assign ctrl_o.adc_on_a    = adc_q[2];
   assign ctrl_o.adc_oe_b    = adc_q[1];
   assign ctrl_o.adc_on_b    = adc_q[0];
   // PHY held in reset while the bit is set
   assign ctrl_o.phy_reset_n = ~phy_q;

   // Hardware LED sources on bits 4 to 1
   assign led_hw = {3'b000, hw_i.run_tx, hw_i.run_rx, hw_i.clk_status,
                    hw_i.serdes_link_up, 1'b0};

   // led_src bit set selects hardware
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   // Decoder returns to idle after every strobe
   a_no_back_to_back_rd : assert property (@(posedge wb_clk) disable iff (wb_rst)
      (req_i.stb && !req_i.we) |=> !(req_i.stb && !req_i.we))
      else $error("settings_regs read strobe on two consecutive cycles");

endmodule

/* status_readback.sv */
// Read-back status block
// Compat number, strap word, raw irq lines and cycle counter
`timescale 1ns/1ps
`include "u2_defs.svh"

module status_readback (
   input  logic               wb_clk,
   input  logic               wb_rst,
   input  u2_pkg::slv_req_t   req_i,
   output logic [`U2_DW-1:0]  rd_dat_o,
   input  u2_pkg::hw_status_t hw_i,
   input  u2_pkg::irq_vec_t   irq_i
);

   logic [`U2_DW-1:0] cycles_q;
   logic [`U2_DW-1:0] strap;

   ////////////////////////////////////////////////////////////
   // Free-running cycle counter
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         cycles_q <= '0;
      end else begin
         cycles_q <= cycles_q + 1'b1;
      end
   end

   // Sim flag on top and divider straps at the bottom
   assign strap = {hw_i.sim_mode, 27'd0, hw_i.clock_divider};

   ////////////////////////////////////////////////////////////
   // Word mux by index
   // Write strobes have nothing to land on here
   always_comb begin
      case (req_i.idx)
         `U2_RB_COMPAT: rd_dat_o = `U2_COMPAT_NUM;
         `U2_RB_STRAP:  rd_dat_o = strap;
         `U2_RB_IRQ:    rd_dat_o = {{(`U2_DW-`U2_IRQ_W){1'b0}}, irq_i};
         `U2_RB_CYCLES: rd_dat_o = cycles_q;
         default:       rd_dat_o = '0;
      endcase
   end

endmodule

/* tb_u2_ctrl.sv */
// Testbench for the control bus top level
// Stimulus table, Wishbone master task, compare tasks and watchdog
`timescale 1ns/1ps
`include "u2_defs.svh"

module tb_u2_ctrl;

   typedef enum {op_wr, op_rd, op_irq, op_hw, op_nop} op_e;
   typedef enum {chk_word, chk_ctrl, chk_leds, chk_int, chk_err, chk_incr} chk_e;

   // One row of the stimulus table
   typedef struct {
      string       name;
      op_e         op;
      logic [15:0] adr;
      logic [31:0] dat;
      chk_e        chk;
      logic [31:0] exp;
   } test_t;

   logic                 wb_clk;
   logic                 wb_rst;
   u2_pkg::wb_m2s_t      wb_i;
   u2_pkg::wb_s2m_t      wb_o;
   u2_pkg::hw_status_t   hw_i;
   u2_pkg::irq_vec_t     irq_i;
   u2_pkg::ctrl_out_t    ctrl_o;
   logic [`U2_LED_W-1:0] leds_o;
   logic                 int_o;

   test_t              tests[$];
   int                 errors;
   int                 bus_timeouts;
   int                 cycle_cnt;
   int                 cycle_limit = 0;
   logic [31:0]        lfsr_q;
   logic [31:0]        prev_cycles;

   // Reference copy of the board registers and inputs
   logic [4:0]         m_clk;
   logic [3:0]         m_ser;
   logic [3:0]         m_adc;
   logic               m_phy;
   logic [7:0]         m_sw;
   logic [7:0]         m_src;
   u2_pkg::hw_status_t m_hw;
   u2_pkg::irq_vec_t   m_irq;

   u2_ctrl_top u_u2_ctrl_top (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .wb_i   (wb_i),
      .wb_o   (wb_o),
      .hw_i   (hw_i),
      .irq_i  (irq_i),
      .ctrl_o (ctrl_o),
      .leds_o (leds_o),
      .int_o  (int_o)
   );

   initial begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   ////////////////////////////////////////////////////////////
   // Random source
   // Galois LFSR, one step per bit
   function automatic logic lfsr_bit();
      logic lsb;
      lsb = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (lsb) begin
         lfsr_q = lfsr_q ^ 32'h8020_0003;
      end
      return lsb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         v[i] = lfsr_bit();
      end
      return v;
   endfunction

   ////////////////////////////////////////////////////////////
   // Expected values from the register map
   function automatic u2_pkg::ctrl_out_t exp_ctrl();
      u2_pkg::ctrl_out_t c;
      c.clock_ready = m_clk[4];
      c.clk_en      = m_clk[3:2];
      c.clk_sel     = m_clk[1:0];
      c.ser_enable  = m_ser[3];
      c.ser_prbsen  = m_ser[2];
      c.ser_loopen  = m_ser[1];
      c.ser_rx_en   = m_ser[0];
      c.adc_oe_a    = m_adc[3];
      c.adc_on_a    = m_adc[2];
      c.adc_oe_b    = m_adc[1];
      c.adc_on_b    = m_adc[0];
      // Active-low PHY reset
      c.phy_reset_n = !m_phy;
      return c;
   endfunction

   function automatic logic [7:0] exp_leds();
      logic [7:0] hw_vec;
      logic [7:0] v;
      int         i;
      hw_vec    = 8'h00;
      hw_vec[4] = m_hw.run_tx;
      hw_vec[3] = m_hw.run_rx;
      hw_vec[2] = m_hw.clk_status;
      hw_vec[1] = m_hw.serdes_link_up;
      // Per bit, hardware when led_src set
      for (i = 0; i < 8; i++) begin
         v[i] = m_src[i] ? hw_vec[i] : m_sw[i];
      end
      return v;
   endfunction

   function automatic logic [31:0] ctrl_word();
      return {18'd0, exp_ctrl()};
   endfunction

   function automatic logic [31:0] leds_word();
      return {24'd0, exp_leds()};
   endfunction

   function automatic void model_write(input logic [7:0] idx, input logic [31:0] d);
      case (idx)
         `U2_SR_CLK:     m_clk = d[4:0];
         `U2_SR_SERDES:  m_ser = d[3:0];
         `U2_SR_ADC:     m_adc = d[3:0];
         `U2_SR_LED_SW:  m_sw  = d[7:0];
         `U2_SR_PHY:     m_phy = d[0];
         `U2_SR_LED_SRC: m_src = d[7:0];
         default: ;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Table construction
   function automatic void push_test(input string name, input op_e op, input logic [15:0] adr,
                                     input logic [31:0] dat, input chk_e chk,
                                     input logic [31:0] exp);
      test_t t;
      t.name = name;
      t.op   = op;
      t.adr  = adr;
      t.dat  = dat;
      t.chk  = chk;
      t.exp  = exp;
      tests.push_back(t);
   endfunction

   function automatic void add_setting(input string name, input logic [7:0] idx,
                                       input chk_e chk);
      logic [31:0] d;
      d = rand_bits(32);
      model_write(idx, d);
      push_test(name, op_wr, 16'hD400 | {6'd0, idx, 2'b00}, d, chk,
                (chk == chk_leds) ? leds_word() : ctrl_word());
   endfunction

   function automatic void add_hw(input string name);
      logic [31:0] d;
      d = rand_bits(9);
      m_hw = d[8:0];
      push_test(name, op_hw, 16'h0000, d, chk_leds, leds_word());
   endfunction

   function automatic void build_tests();
      push_test("reset_ctrl", op_nop, 16'h0000, 32'h0, chk_ctrl, ctrl_word());
      push_test("reset_leds", op_nop, 16'h0000, 32'h0, chk_leds, leds_word());
      push_test("reset_int", op_nop, 16'h0000, 32'h0, chk_int, 32'd0);
      add_setting("sr_clk", `U2_SR_CLK, chk_ctrl);
      add_setting("sr_serdes", `U2_SR_SERDES, chk_ctrl);
      add_setting("sr_adc", `U2_SR_ADC, chk_ctrl);
      add_setting("sr_phy", `U2_SR_PHY, chk_ctrl);
      add_setting("sr_phy_again", `U2_SR_PHY, chk_ctrl);
      add_setting("sr_unused", 8'd6, chk_ctrl);
      // LED source mux
      add_hw("hw_first");
      add_setting("led_sw", `U2_SR_LED_SW, chk_leds);
      add_setting("led_src", `U2_SR_LED_SRC, chk_leds);
      add_hw("hw_second");
      add_setting("led_src_again", `U2_SR_LED_SRC, chk_leds);
      // Line 3 rises while masked
      m_irq = 16'h0008;
      push_test("irq_masked", op_irq, 16'h0000, 32'h8, chk_int, 32'd0);
      push_test("irq_enable", op_wr, 16'hD800, 32'h8, chk_int, 32'd1);
      push_test("irq_pending_rd", op_rd, 16'hD804, 32'h0, chk_word, 32'h8);
      push_test("irq_clear", op_wr, 16'hD804, 32'h8, chk_int, 32'd0);
      // Status words
      push_test("rb_compat", op_rd, 16'hCC00, 32'h0, chk_word, 32'd1);
      push_test("rb_strap", op_rd, 16'hCC04, 32'h0, chk_word,
                {m_hw.sim_mode, 27'd0, m_hw.clock_divider});
      push_test("rb_irq", op_rd, 16'hCC08, 32'h0, chk_word, {16'd0, m_irq});
      push_test("rb_cycles_first", op_rd, 16'hCC0C, 32'h0, chk_incr, 32'd0);
      push_test("rb_cycles_second", op_rd, 16'hCC0C, 32'h0, chk_incr, 32'd0);
      push_test("rb_unused", op_rd, 16'hCC1C, 32'h0, chk_word, 32'd0);
      push_test("rb_settings", op_rd, 16'hD400, 32'h0, chk_word, 32'd0);
      // Nothing decodes at the bottom of the map
      push_test("unmapped_wr", op_wr, 16'h0000, rand_bits(32), chk_err, 32'd1);
      push_test("unmapped_ctrl", op_nop, 16'h0000, 32'h0, chk_ctrl, ctrl_word());
      push_test("unmapped_leds", op_nop, 16'h0000, 32'h0, chk_leds, leds_word());
   endfunction

   ////////////////////////////////////////////////////////////
   // Compare tasks
   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("Error %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_ctrl(input string name, input u2_pkg::ctrl_out_t exp,
                             input u2_pkg::ctrl_out_t act);
      if (act !== exp) begin
         $display("Error %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_leds(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         $display("Error %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Error %s: expected %b, actual %b", name, exp, act);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Wishbone master
   // Entered 1 ns after an edge, leaves in the response cycle
   task automatic bus_access(input logic we, input logic [15:0] adr, input logic [31:0] dat,
                             output logic [31:0] rd, output logic err);
      int   n;
      logic done;
      rd   = '0;
      err  = 1'b0;
      done = 1'b0;
      n    = 0;
      wb_i.cyc = 1'b1;
      wb_i.stb = 1'b1;
      wb_i.we  = we;
      wb_i.adr = adr;
      wb_i.dat = dat;
      while (!done && n < 4) begin
         @(posedge wb_clk);
         #1;
         n++;
         if (wb_o.ack || wb_o.err) begin
            done = 1'b1;
            rd   = wb_o.dat;
            err  = wb_o.err;
         end
      end
      wb_i.cyc = 1'b0;
      wb_i.stb = 1'b0;
      wb_i.we  = 1'b0;
      if (!done) begin
         $display("Bus request to address %h got neither ack nor err within 4 cycles", adr);
         bus_timeouts++;
      end
   endtask

   task automatic run_test(input test_t t);
      logic [31:0] rd;
      logic        err;
      rd  = '0;
      err = 1'b0;
      case (t.op)
         op_wr, op_rd: begin
            bus_access(t.op == op_wr, t.adr, t.dat, rd, err);
            check_bit({t.name, "_err"}, t.chk == chk_err, err);
         end
         op_irq: begin
            irq_i = t.dat[15:0];
            // Edge register, then pending latch
            repeat (2) @(posedge wb_clk);
            #1;
         end
         op_hw: begin
            hw_i = t.dat[8:0];
            @(posedge wb_clk);
            #1;
         end
         default: ;
      endcase
      case (t.chk)
         chk_word: check_word(t.name, t.exp, rd);
         chk_ctrl: check_ctrl(t.name, t.exp[13:0], ctrl_o);
         chk_leds: check_leds(t.name, t.exp[7:0], leds_o);
         chk_int:  check_bit(t.name, t.exp[0], int_o);
         chk_incr: begin
            check_bit(t.name, 1'b1, rd > prev_cycles);
            prev_cycles = rd;
         end
         default: ;
      endcase
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   initial begin
      int k;
      wb_rst       = 1'b1;
      wb_i         = '0;
      hw_i         = '0;
      irq_i        = '0;
      errors       = 0;
      bus_timeouts = 0;
      lfsr_q       = 32'h7868;
      prev_cycles  = '0;
      m_clk        = '0;
      m_ser        = '0;
      m_adc        = '0;
      m_phy        = 1'b0;
      m_sw         = '0;
      m_src        = 8'h1E;
      m_hw         = '0;
      m_irq        = '0;
      build_tests();
      cycle_limit = 40 * tests.size() + 100;
      repeat (8) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;
      for (k = 0; k < tests.size(); k++) begin
         @(posedge wb_clk);
         #1;
         run_test(tests[k]);
      end
      $display("Check errors: %0d, bus timeouts: %0d", errors, bus_timeouts);
      if (errors == 0 && bus_timeouts == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // Watchdog on the whole run
   initial begin
      cycle_cnt = 0;
      wait (cycle_limit > 0);
      while (cycle_cnt < cycle_limit) begin
         @(posedge wb_clk);
         cycle_cnt++;
      end
      $display("Run stopped after %0d cycles before the table finished", cycle_cnt);
      $display("Errors found");
      $finish;
   end

endmodule

/* u2_ctrl_top.sv */
// Control bus top level
// Wishbone decoder feeding settings, status and interrupt slaves
`timescale 1ns/1ps
`include "u2_defs.svh"

module u2_ctrl_top (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  u2_pkg::wb_m2s_t      wb_i,
   output u2_pkg::wb_s2m_t      wb_o,
   input  u2_pkg::hw_status_t   hw_i,
   input  u2_pkg::irq_vec_t     irq_i,
   output u2_pkg::ctrl_out_t    ctrl_o,
   output logic [`U2_LED_W-1:0] leds_o,
   output logic                 int_o
);

   u2_pkg::slv_req_t  status_req;
   u2_pkg::slv_req_t  settings_req;
   u2_pkg::slv_req_t  pic_req;
   logic [`U2_DW-1:0] status_dat;
   logic [`U2_DW-1:0] settings_dat;
   logic [`U2_DW-1:0] pic_dat;

   ////////////////////////////////////////////////////////////
   // Bus port and decode
   wb_decoder u_wb_decoder (
      .wb_clk         (wb_clk),
      .wb_rst         (wb_rst),
      .wb_i           (wb_i),
      .wb_o           (wb_o),
      .status_req_o   (status_req),
      .settings_req_o (settings_req),
      .pic_req_o      (pic_req),
      .status_dat_i   (status_dat),
      .settings_dat_i (settings_dat),
      .pic_dat_i      (pic_dat)
   );

   ////////////////////////////////////////////////////////////
   // Slaves
   settings_regs u_settings_regs (
      .wb_clk   (wb_clk),
      .wb_rst   (wb_rst),
      .req_i    (settings_req),
      .rd_dat_o (settings_dat),
      .hw_i     (hw_i),
      .ctrl_o   (ctrl_o),
      .leds_o   (leds_o)
   );

   status_readback u_status_readback (
      .wb_clk   (wb_clk),
      .wb_rst   (wb_rst),
      .req_i    (status_req),
      .rd_dat_o (status_dat),
      .hw_i     (hw_i),
      .irq_i    (irq_i)
   );

   pic u_pic (
      .wb_clk   (wb_clk),
      .wb_rst   (wb_rst),
      .req_i    (pic_req),
      .rd_dat_o (pic_dat),
      .irq_i    (irq_i),
      .int_o    (int_o)
   );

endmodule

/* u2_defs.svh */
// Shared constants for the control bus core
// Bus widths, decode slots, register offsets and reset values
`ifndef U2_DEFS_SVH
`define U2_DEFS_SVH

////////////////////////////////////////////////////////////
// Bus geometry
`define U2_DW            32
`define U2_AW            16
`define U2_IDX_W         8
`define U2_IRQ_W         16
`define U2_LED_W         8

// Slave select taken from address bits 15 to 10
`define U2_DECODE_W      6
`define U2_SLOT_STATUS   6'b110011
`define U2_SLOT_SETTINGS 6'b110101
`define U2_SLOT_PIC      6'b110110

////////////////////////////////////////////////////////////
// Setting register addresses
`define U2_SR_CLK        8'd0
`define U2_SR_SERDES     8'd1
`define U2_SR_ADC        8'd2
`define U2_SR_LED_SW     8'd3
`define U2_SR_PHY        8'd4
`define U2_SR_LED_SRC    8'd8

// LEDs 4 to 1 under hardware control out of reset
`define U2_LED_SRC_RESET 8'h1E

// Bump when the register map changes
`define U2_COMPAT_NUM    32'd1

// Read-back word indices
`define U2_RB_COMPAT     8'd0
`define U2_RB_STRAP      8'd1
`define U2_RB_IRQ        8'd2
`define U2_RB_CYCLES     8'd3

// Interrupt controller offsets
`define U2_PIC_ENABLE    8'd0
`define U2_PIC_PENDING   8'd1

`endif

/* u2_pkg.sv */
// Types for the control bus core
// Bus bundles, slave request, board lines and FSM enums
`include "u2_defs.svh"

package u2_pkg;

   ////////////////////////////////////////////////////////////
   // Wishbone bundles
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [`U2_AW-1:0] adr;
      logic [`U2_DW-1:0] dat;
   } wb_m2s_t;

   typedef struct packed {
      logic [`U2_DW-1:0] dat;
      logic              ack;
      logic              err;
   } wb_s2m_t;

   // One-cycle request from decoder to a slave
   typedef struct packed {
      logic                stb;
      logic                we;
      logic [`U2_IDX_W-1:0] idx;
      logic [`U2_DW-1:0]   dat;
   } slv_req_t;

   ////////////////////////////////////////////////////////////
   // Board lines
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_reset_n;
   } ctrl_out_t;

   typedef struct packed {
      logic       run_tx;
      logic       run_rx;
      logic       clk_status;
      logic       serdes_link_up;
      logic       sim_mode;
      logic [3:0] clock_divider;
   } hw_status_t;

   typedef logic [`U2_IRQ_W-1:0] irq_vec_t;

   // Decoder FSM and decode result
   typedef enum logic {st_idle, st_ack} bus_state_e;

   typedef enum logic [1:0] {sel_status, sel_settings, sel_pic, sel_none} slave_sel_e;

endpackage

/* wb_decoder.sv */
// Wishbone slave port with address decode
// Acknowledge FSM and registered read data steering
`timescale 1ns/1ps
`include "u2_defs.svh"

module wb_decoder (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  u2_pkg::wb_m2s_t   wb_i,
   output u2_pkg::wb_s2m_t   wb_o,
   output u2_pkg::slv_req_t  status_req_o,
   output u2_pkg::slv_req_t  settings_req_o,
   output u2_pkg::slv_req_t  pic_req_o,
   input  logic [`U2_DW-1:0] status_dat_i,
   input  logic [`U2_DW-1:0] settings_dat_i,
   input  logic [`U2_DW-1:0] pic_dat_i
);

   u2_pkg::bus_state_e state_q;
   u2_pkg::slave_sel_e sel;
   logic               fire;
   logic               ack_q;
   logic               err_q;
   logic [`U2_DW-1:0]  rd_mux;
   logic [`U2_DW-1:0]  dat_q;

   ////////////////////////////////////////////////////////////
   // Address decode on the top six bits
   always_comb begin
      case (wb_i.adr[`U2_AW-1 -: `U2_DECODE_W])
         `U2_SLOT_STATUS:   sel = u2_pkg::sel_status;
         `U2_SLOT_SETTINGS: sel = u2_pkg::sel_settings;
         `U2_SLOT_PIC:      sel = u2_pkg::sel_pic;
         default:           sel = u2_pkg::sel_none;
      endcase
   end

   // Request accepted only from idle
   assign fire = (state_q == u2_pkg::st_idle) && wb_i.cyc && wb_i.stb;

   // Shared fields to every slave
   always_comb begin
      status_req_o.we  = wb_i.we;
      status_req_o.idx = wb_i.adr[`U2_IDX_W+1:2];
      status_req_o.dat = wb_i.dat;
      status_req_o.stb = fire && (sel == u2_pkg::sel_status);
      settings_req_o     = status_req_o;
      settings_req_o.stb = fire && (sel == u2_pkg::sel_settings);
      pic_req_o          = status_req_o;
      pic_req_o.stb      = fire && (sel == u2_pkg::sel_pic);
   end

   // Read data from the addressed slave
   always_comb begin
      case (sel)
         u2_pkg::sel_status:   rd_mux = status_dat_i;
         u2_pkg::sel_settings: rd_mux = settings_dat_i;
         u2_pkg::sel_pic:      rd_mux = pic_dat_i;
         default:              rd_mux = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Acknowledge FSM
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         state_q <= u2_pkg::st_idle;
         ack_q   <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         case (state_q)
            u2_pkg::st_idle: begin
               // Unmapped slot answers with err
               ack_q <= fire && (sel != u2_pkg::sel_none);
               err_q <= fire && (sel == u2_pkg::sel_none);
               if (fire) begin
                  state_q <= u2_pkg::st_ack;
               end
            end
            default: begin
               state_q <= u2_pkg::st_idle;
               ack_q   <= 1'b0;
               err_q   <= 1'b0;
            end
         endcase
      end
   end

   // Read word captured with the strobe
   always_ff @(posedge wb_clk) begin
      if (fire) begin
         dat_q <= rd_mux;
      end
   end

   assign wb_o.dat = dat_q;
   assign wb_o.ack = ack_q;
   assign wb_o.err = err_q;

   // Exactly one response kind per request
   a_ack_err_excl : assert property (@(posedge wb_clk) disable iff (wb_rst)
      !(wb_o.ack && wb_o.err))
      else $error("wb_decoder ack and err high together");

   // Single-cycle acknowledge
   a_ack_single : assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_o.ack |=> !wb_o.ack)
      else $error("wb_decoder ack held for two cycles");

endmodule
